// ==== sys_bus.f ====
verilog/sys_bus_pkg.sv
verilog/beat_buffer.sv
verilog/bus_arbiter.sv
verilog/bus_ram.sv
verilog/kbd_bus_controller.sv
verilog/cache_bus_controller.sv
verilog/sys_bus_top.sv
verif/sys_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the system bus testbench with Verilator, run it, search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sys_bus.f \
   --top-module sys_bus_tb -o sys_bus_sim > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sys_bus_sim > sim.log 2>&1 \
   && grep -q "^TB PASSED$" sim.log \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verif/sys_bus_tb.sv ====
/* System bus testbench: clock, reset, key and miss stimulus, reference
   line packing, compare tasks and watchdog */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_tb
   import sys_bus_pkg::*;
();

   localparam addr_t KBD_BASE    = 16'h0100;
   localparam int    RING        = 4;
   localparam int    NUM_TESTS   = 15;
   localparam int    WAIT_LIMIT  = 200;
   localparam int    WATCHDOG_NS = NUM_TESTS * 64 * 40 + 2000;

   logic      bus_clk;
   logic      rst_n;
   logic      key_stb;
   key_code_t key_code;
   logic      kbd_ready;
   logic      kbd_done;
   logic      miss_stb;
   addr_t     miss_addr;
   logic      cache_busy;
   logic      fill_stb;
   line_t     fill_line;

   integer    seed;
   int        errors;
   int        done_cnt;
   int        fill_cnt;
   int        exp_dones;
   int        exp_fills;
   int        wr_slot;
   line_t     exp_fill;
   key_code_t cur_codes [16];
   key_code_t model_codes [RING][16];

   sys_bus_top dut_i (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .key_stb    (key_stb),
      .key_code   (key_code),
      .kbd_ready  (kbd_ready),
      .kbd_done   (kbd_done),
      .miss_stb   (miss_stb),
      .miss_addr  (miss_addr),
      .cache_busy (cache_busy),
      .fill_stb   (fill_stb),
      .fill_line  (fill_line)
   );

   always #20 bus_clk = ~bus_clk;

   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp)
      begin
         errors++;
         $display("Fail %s got %0h expected %0h", name, got, exp);
      end
   endtask

   // Code i goes to byte i mod 4 of word i div 4
   function automatic line_t pack_line(input int slot);
      line_t l;
      int    i;
      l = '0;
      for (i = 0; i < 16; i++)
         l[(i / 4) * 32 + (i % 4) * 8 +: 8] = model_codes[slot][i];
      return l;
   endfunction

   function automatic addr_t line_addr_of(input int slot);
      return KBD_BASE + addr_t'(slot * BURST_BYTES);
   endfunction

   task automatic push_key(input key_code_t code);
      key_stb  = 1'b1;
      key_code = code;
      @(negedge bus_clk);
      key_stb  = 1'b0;
   endtask

   task automatic wait_kbd_done;
      int n;
      bit seen;
      seen = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !seen; n++)
      begin
         if (kbd_done)
            seen = 1'b1;
         else
         begin
            check_bit("kbd_ready", kbd_ready, 1'b0);
            @(negedge bus_clk);
         end
      end
      if (!seen)
      begin
         errors++;
         $display("Keyboard flush did not finish within %0d cycles", WAIT_LIMIT);
      end
      @(negedge bus_clk);
   endtask

   task automatic flush_ring;
      int        i;
      key_code_t c;
      for (i = 0; i < 16; i++)
      begin
         check_bit("kbd_ready", kbd_ready, 1'b1);
         c = key_code_t'($random(seed));
         cur_codes[i] = c;
         push_key(c);
      end
      exp_dones++;
      // A code pulsed while the flush is pending must be dropped
      check_bit("kbd_ready", kbd_ready, 1'b0);
      push_key(~cur_codes[0]);
      wait_kbd_done();
   endtask

   task automatic read_line(input int slot);
      int n;
      bit seen;
      exp_fill  = pack_line(slot);
      exp_fills++;
      miss_stb  = 1'b1;
      miss_addr = line_addr_of(slot);
      @(negedge bus_clk);
      miss_stb  = 1'b0;
      seen      = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !seen; n++)
      begin
         check_bit("cache_busy", cache_busy, 1'b1);
         if (fill_stb)
            seen = 1'b1;
         else
            @(negedge bus_clk);
      end
      if (!seen)
      begin
         errors++;
         $display("Cache line fill did not finish within %0d cycles", WAIT_LIMIT);
      end
      @(negedge bus_clk);
      check_bit("cache_busy", cache_busy, 1'b0);
   endtask

   // Sixteenth code and a miss in the same cycle, both masters request together
   task automatic contend_flush_and_miss(input int slot);
      int        i;
      int        n;
      key_code_t c;
      bit        seen_done;
      bit        seen_fill;
      for (i = 0; i < 15; i++)
      begin
         c = key_code_t'($random(seed));
         cur_codes[i] = c;
         push_key(c);
      end
      c = key_code_t'($random(seed));
      cur_codes[15] = c;
      exp_dones++;
      exp_fill  = pack_line(slot);
      exp_fills++;
      key_stb   = 1'b1;
      key_code  = c;
      miss_stb  = 1'b1;
      miss_addr = line_addr_of(slot);
      @(negedge bus_clk);
      key_stb   = 1'b0;
      miss_stb  = 1'b0;
      seen_done = 1'b0;
      seen_fill = 1'b0;
      for (n = 0; n < WAIT_LIMIT && !(seen_done && seen_fill); n++)
      begin
         if (!seen_fill)
            check_bit("cache_busy", cache_busy, 1'b1);
         if (!seen_done)
            check_bit("kbd_ready", kbd_ready, 1'b0);
         if (fill_stb)
            seen_fill = 1'b1;
         if (kbd_done)
            seen_done = 1'b1;
         // Second miss and a stray key while both are busy
         miss_stb  = (n == 2);
         miss_addr = line_addr_of(3);
         key_stb   = (n == 1);
         key_code  = ~cur_codes[0];
         @(negedge bus_clk);
      end
      miss_stb = 1'b0;
      key_stb  = 1'b0;
      if (!(seen_done && seen_fill))
      begin
         errors++;
         $display("Contending flush and line fill did not both finish");
      end
      repeat (20) @(negedge bus_clk);
   endtask

   // Compare process, also keeps the ring model up to date
   always @(negedge bus_clk)
   begin : compare
      int i;
      if (rst_n)
      begin
         if (kbd_done)
         begin
            done_cnt++;
            check_addr("kbd line_addr", dut_i.kbd_i.line_addr, line_addr_of(wr_slot));
            for (i = 0; i < 16; i++)
               model_codes[wr_slot][i] = cur_codes[i];
            wr_slot = (wr_slot + 1) % RING;
         end
         if (fill_stb)
         begin
            fill_cnt++;
            check_line("fill_line", fill_line, exp_fill);
         end
      end
   end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin : stimulus
      int t;
      seed      = 32'heacf_b927;
      errors    = 0;
      done_cnt  = 0;
      fill_cnt  = 0;
      exp_dones = 0;
      exp_fills = 0;
      wr_slot   = 0;
      exp_fill  = '0;
      bus_clk   = 1'b0;
      rst_n     = 1'b0;
      key_stb   = 1'b0;
      key_code  = '0;
      miss_stb  = 1'b0;
      miss_addr = '0;
      repeat (5) @(negedge bus_clk);
      rst_n = 1'b1;
      @(negedge bus_clk);
      check_bit("kbd_ready", kbd_ready, 1'b1);
      check_bit("cache_busy", cache_busy, 1'b0);
      check_bit("kbd_done", kbd_done, 1'b0);
      check_bit("fill_stb", fill_stb, 1'b0);
      for (t = 0; t < RING; t++)
         flush_ring();
      for (t = 0; t < RING; t++)
         read_line(t);
      // Fifth flush wraps to the ring base
      flush_ring();
      read_line(0);
      read_line(1);
      contend_flush_and_miss(2);
      // Line written by the keyboard during contention
      read_line(1);
      check_count("kbd_done count", done_cnt, exp_dones);
      check_count("fill_stb count", fill_cnt, exp_fills);
      $display("Errors: %0d, keyboard flushes: %0d, line fills: %0d",
               errors, done_cnt, fill_cnt);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/sys_bus_top.sv ====
/* System bus top: arbiter, RAM slave, keyboard and cache bus masters */
`timescale 1ns/1ps
`default_nettype none

module sys_bus_top
   import sys_bus_pkg::*;
#(
   parameter addr_t KBD_BASE       = 16'h0100,
   parameter int    KBD_RING_LINES = 4,
   parameter int    RAM_WORDS      = 1024
)
(
   input  wire logic      bus_clk,
   input  wire logic      rst_n,
   input  wire logic      key_stb,
   input  wire key_code_t key_code,
   output logic           kbd_ready,
   output logic           kbd_done,
   input  wire logic      miss_stb,
   input  wire addr_t     miss_addr,
   output logic           cache_busy,
   output logic           fill_stb,
   output line_t          fill_line
);

   // Bit 0 is the keyboard, bit 1 the cache
   logic [1:0] br;
   logic [1:0] bg;
   bus_mst_t   mst_kbd;
   bus_mst_t   mst_cache;
   bus_mst_t   bus_m;
   bus_slv_t   bus_s;

   bus_arbiter arb_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .br        (br),
      .bg        (bg),
      .mst_kbd   (mst_kbd),
      .mst_cache (mst_cache),
      .bus_m     (bus_m)
   );

   bus_ram #(
      .RAM_WORDS (RAM_WORDS)
   ) ram_i (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .bus_m   (bus_m),
      .bus_s   (bus_s)
   );

   kbd_bus_controller #(
      .KBD_BASE       (KBD_BASE),
      .KBD_RING_LINES (KBD_RING_LINES)
   ) kbd_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .key_stb   (key_stb),
      .key_code  (key_code),
      .kbd_ready (kbd_ready),
      .kbd_done  (kbd_done),
      .br        (br[0]),
      .bg        (bg[0]),
      .mst       (mst_kbd),
      .slv       (bus_s)
   );

   cache_bus_controller cache_i (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .miss_stb   (miss_stb),
      .miss_addr  (miss_addr),
      .cache_busy (cache_busy),
      .fill_stb   (fill_stb),
      .fill_line  (fill_line),
      .br         (br[1]),
      .bg         (bg[1]),
      .mst        (mst_cache),
      .slv        (bus_s)
   );

endmodule

`default_nettype wire

// ==== verilog/cache_bus_controller.sv ====
/* Cache line-fill bus master: reads one four-word burst on a miss and
   returns the assembled line */
`timescale 1ns/1ps
`default_nettype none

module cache_bus_controller
   import sys_bus_pkg::*;
(
   input  wire logic     bus_clk,
   input  wire logic     rst_n,
   input  wire logic     miss_stb,
   input  wire addr_t    miss_addr,
   output logic          cache_busy,
   output logic          fill_stb,
   output line_t         fill_line,
   output logic          br,
   input  wire logic     bg,
   output bus_mst_t      mst,
   input  wire bus_slv_t slv
);

   localparam int BW = $clog2(BURST_BEATS);

   ctrl_state_t             state_q;
   addr_t                   addr_q;
   size_t                   size_q;
   logic [BW-1:0]           beat_idx;
   logic                    fill_wr;
   word_t [BURST_BEATS-1:0] words;

   assign cache_busy = (state_q != ST_IDLE);
   assign fill_stb   = (state_q == ST_DONE);
   assign br         = (state_q == ST_REQ) || (state_q == ST_MSTR) || (state_q == ST_RD);
   assign fill_wr    = (state_q == ST_RD) && slv.ack;

   beat_buffer #(
      .item_t (word_t),
      .DEPTH  (BURST_BEATS)
   ) line_buf_i (
      .bus_clk (bus_clk),
      .wr_en   (fill_wr),
      .wr_idx  (beat_idx),
      .wr_item (slv.rdata),
      .items   (words)
   );

   // Lowest address word sits in the lowest bits
   assign fill_line = words;

   always_ff @(posedge bus_clk)
   begin
      if (miss_stb && !cache_busy)
         addr_q <= miss_addr;
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= ST_IDLE;
         size_q   <= '0;
         beat_idx <= '0;
      end
      else
      begin
         unique case (state_q)
            ST_IDLE:
               if (miss_stb)
                  state_q <= ST_REQ;
            ST_REQ:
               if (bg)
               begin
                  state_q  <= ST_MSTR;
                  size_q   <= size_t'(BURST_BYTES);
                  beat_idx <= '0;
               end
            ST_MSTR:
               state_q <= ST_RD;
            ST_RD:
               if (slv.ack)
               begin
                  size_q   <= size_q - size_t'(BEAT_BYTES);
                  beat_idx <= beat_idx + 1'b1;
                  if (size_q == size_t'(BEAT_BYTES))
                     state_q <= ST_DONE;
               end
            ST_DONE:
               state_q <= ST_IDLE;
            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   always_comb
   begin
      mst       = '0;
      mst.hdr   = (state_q == ST_MSTR);
      mst.beat  = (state_q == ST_RD);
      mst.rw    = 1'b1;
      mst.addr  = addr_q;
      mst.size  = size_q;
   end

endmodule

`default_nettype wire

// ==== verilog/kbd_bus_controller.sv ====
/* Keyboard bus master: gathers sixteen key codes and writes them as one
   burst into the RAM ring, then pulses done */
`timescale 1ns/1ps
`default_nettype none

module kbd_bus_controller
   import sys_bus_pkg::*;
#(
   parameter addr_t KBD_BASE       = 16'h0100,
   parameter int    KBD_RING_LINES = 4
)
(
   input  wire logic      bus_clk,
   input  wire logic      rst_n,
   input  wire logic      key_stb,
   input  wire key_code_t key_code,
   output logic           kbd_ready,
   output logic           kbd_done,
   output logic           br,
   input  wire logic      bg,
   output bus_mst_t       mst,
   input  wire bus_slv_t  slv
);

   // One code per byte of the burst
   localparam int KEYS = BURST_BYTES;
   localparam int CW   = $clog2(KEYS);
   localparam int BW   = $clog2(BURST_BEATS);
   localparam int LW   = (KBD_RING_LINES > 1) ? $clog2(KBD_RING_LINES) : 1;

   ctrl_state_t          state_q;
   logic [CW-1:0]        cnt_q;
   logic [LW-1:0]        line_q;
   logic [BW-1:0]        beat_idx;
   size_t                size_q;
   logic                 key_acc;
   key_code_t [KEYS-1:0] codes;
   line_t                kbd_line;
   addr_t                line_addr;

   assign kbd_ready = (state_q == ST_IDLE);
   assign kbd_done  = (state_q == ST_DONE);
   assign br        = (state_q == ST_REQ) || (state_q == ST_MSTR) || (state_q == ST_WR);
   assign key_acc   = key_stb && kbd_ready;

   beat_buffer #(
      .item_t (key_code_t),
      .DEPTH  (KEYS)
   ) code_buf_i (
      .bus_clk (bus_clk),
      .wr_en   (key_acc),
      .wr_idx  (cnt_q),
      .wr_item (key_code),
      .items   (codes)
   );

   // Little-endian packing falls out of the packed array order
   assign kbd_line  = codes;
   assign line_addr = KBD_BASE + addr_t'(line_q) * addr_t'(BURST_BYTES);

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= ST_IDLE;
         cnt_q    <= '0;
         line_q   <= '0;
         beat_idx <= '0;
         size_q   <= '0;
      end
      else
      begin
         if (key_acc)
            cnt_q <= cnt_q + 1'b1;
         unique case (state_q)
            ST_IDLE:
               if (key_acc && cnt_q == CW'(KEYS - 1))
                  state_q <= ST_REQ;
            ST_REQ:
               if (bg)
               begin
                  state_q  <= ST_MSTR;
                  size_q   <= size_t'(BURST_BYTES);
                  beat_idx <= '0;
               end
            ST_MSTR:
               state_q <= ST_WR;
            ST_WR:
               if (slv.ack)
               begin
                  size_q   <= size_q - size_t'(BEAT_BYTES);
                  beat_idx <= beat_idx + 1'b1;
                  if (size_q == size_t'(BEAT_BYTES))
                     state_q <= ST_DONE;
               end
            ST_DONE:
            begin
               state_q <= ST_IDLE;
               // Ring wraps after the last line
               line_q  <= (line_q == LW'(KBD_RING_LINES - 1)) ? '0 : line_q + 1'b1;
            end
            default:
               state_q <= ST_IDLE;
         endcase
      end
   end

   always_comb
   begin
      mst       = '0;
      mst.hdr   = (state_q == ST_MSTR);
      mst.beat  = (state_q == ST_WR);
      mst.rw    = 1'b0;
      mst.addr  = line_addr;
      mst.size  = size_q;
      mst.wdata = kbd_line[{beat_idx, 5'b0} +: 32];
   end

   // Size only moves when the RAM acknowledges a beat
   a_size_on_ack: assert property (@(posedge bus_clk) disable iff (!rst_n)
      (state_q == ST_WR && !slv.ack) |=> $stable(size_q));

endmodule

`default_nettype wire

// ==== verilog/bus_ram.sv ====
/* Word-addressed RAM slave: latches the burst header, then answers each
   data beat with an ack after one wait cycle */
`timescale 1ns/1ps
`default_nettype none

module bus_ram
   import sys_bus_pkg::*;
#(
   parameter int RAM_WORDS = 1024
)
(
   input  wire logic     bus_clk,
   input  wire logic     rst_n,
   input  wire bus_mst_t bus_m,
   output bus_slv_t      bus_s
);

   localparam int AW = $clog2(RAM_WORDS);

   word_t           mem [RAM_WORDS];
   word_t           rdata_q;
   logic [AW-1:0]   word_addr;
   logic            rw_q;
   logic            active_q;
   logic            ack_q;
   logic            beat_wait;

   // First cycle of each beat is the wait stage, the ack follows
   assign beat_wait = bus_m.beat && !ack_q;

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         word_addr <= '0;
         rw_q      <= 1'b0;
         active_q  <= 1'b0;
         ack_q     <= 1'b0;
      end
      else if (bus_m.hdr)
      begin
         word_addr <= bus_m.addr[AW+1:2];
         rw_q      <= bus_m.rw;
         active_q  <= 1'b1;
         ack_q     <= 1'b0;
      end
      else
      begin
         ack_q <= beat_wait;
         // Step to the next word once the beat is acknowledged
         if (ack_q)
            word_addr <= word_addr + 1'b1;
         if (active_q && !bus_m.beat)
            active_q <= 1'b0;
      end
   end

   // Storage access happens at the end of the wait stage
   always_ff @(posedge bus_clk)
   begin
      if (beat_wait)
      begin
         if (rw_q)
            rdata_q <= mem[word_addr];
         else
            mem[word_addr] <= bus_m.wdata;
      end
   end

   assign bus_s = '{ack: ack_q, rdata: rdata_q};

   a_beat_after_hdr: assert property (@(posedge bus_clk) disable iff (!rst_n)
      bus_m.beat |-> active_q);

endmodule

`default_nettype wire

// ==== verilog/bus_arbiter.sv ====
/* Round-robin arbiter for two bus masters with the grant-selected bus mux */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
   import sys_bus_pkg::*;
(
   input  wire logic      bus_clk,
   input  wire logic      rst_n,
   input  wire logic [1:0] br,
   output logic [1:0]     bg,
   input  wire bus_mst_t  mst_kbd,
   input  wire bus_mst_t  mst_cache,
   output bus_mst_t       bus_m
);

   // Set when the cache took the last grant, so the keyboard goes first
   logic last_cache;

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bg         <= 2'b00;
         last_cache <= 1'b1;
      end
      else if (bg == 2'b00)
      begin
         // New grant only while the bus is free
         if (br[0] && (!br[1] || last_cache))
         begin
            bg         <= 2'b01;
            last_cache <= 1'b0;
         end
         else if (br[1])
         begin
            bg         <= 2'b10;
            last_cache <= 1'b1;
         end
      end
      else if ((bg & br) == 2'b00)
      begin
         // Owner released its request
         bg <= 2'b00;
      end
   end

   // Only the owner reaches the RAM, idle bus reads as zero
   always_comb
   begin
      unique case (bg)
         2'b01:   bus_m = mst_kbd;
         2'b10:   bus_m = mst_cache;
         default: bus_m = '0;
      endcase
   end

   a_one_grant: assert property (@(posedge bus_clk) disable iff (!rst_n)
      bg != 2'b11);

endmodule

`default_nettype wire

// ==== verilog/beat_buffer.sv ====
/* Indexed item store for one burst, all items visible in parallel */
`timescale 1ns/1ps
`default_nettype none

module beat_buffer #(
   parameter type item_t = logic [7:0],
   parameter int  DEPTH   = 4
)
(
   input  wire logic                     bus_clk,
   input  wire logic                     wr_en,
   input  wire logic [$clog2(DEPTH)-1:0] wr_idx,
   input  wire item_t                    wr_item,
   output item_t [DEPTH-1:0]             items
);

   // Item 0 lands in the lowest bits of the packed output
   always_ff @(posedge bus_clk)
   begin
      if (wr_en)
         items[wr_idx] <= wr_item;
   end

endmodule

`default_nettype wire

// ==== verilog/sys_bus_pkg.sv ====
/* Bus address, size, data and line types, master and slave bus structs,
   one-hot controller states and burst constants */
`default_nettype none

package sys_bus_pkg;

   // Byte address and remaining byte count of a burst
   typedef logic [15:0]  addr_t;
   typedef logic [11:0]  size_t;

   // One data beat, one scan code, one cache line
   typedef logic [31:0]  word_t;
   typedef logic [7:0]   key_code_t;
   typedef logic [127:0] line_t;

   // Driven by a master toward the bus
   typedef struct packed {
      logic  hdr;   // First cycle of a burst
      logic  beat;  // Data beat offered
      logic  rw;    // 1 = read
      addr_t addr;
      size_t size;
      word_t wdata;
   } bus_mst_t;

   // Driven back by the RAM slave
   typedef struct packed {
      logic  ack;   // One pulse per finished beat
      word_t rdata;
   } bus_slv_t;

   // Shared by both bus controllers
   typedef enum logic [5:0] {
      ST_IDLE = 6'b00_0001,
      ST_REQ  = 6'b00_0010,
      ST_MSTR = 6'b00_0100,
      ST_WR   = 6'b00_1000,
      ST_RD   = 6'b01_0000,
      ST_DONE = 6'b10_0000
   } ctrl_state_t;

   localparam int BURST_BYTES = 16;
   localparam int BEAT_BYTES  = 4;
   localparam int BURST_BEATS = BURST_BYTES / BEAT_BYTES;

endpackage

`default_nettype wire
